// File: Makefile
# Verilator build and run for the AXI4 to AXI4-Lite converter

VERILATOR ?= verilator
TB_TOP    ?= axi_to_axi_lite_tb
RTL_TOP   ?= axi_to_axi_lite
FILELIST  ?= axi_to_axi_lite.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: axi_to_axi_lite.f
+incdir+source
source/axi_full_pkg.sv
source/axi_lite_pkg.sv
source/axi_single_if.sv
source/id_fifo.sv
source/axi_burst_splitter.sv
source/axi_id_reflect.sv
source/axi_to_axi_lite.sv
testbench/axi_to_axi_lite_asserts.sv
testbench/axi_to_axi_lite_tb.sv

// File: source/axi_burst_splitter.sv
/* Cuts AXI4 bursts into single-beat requests and rebuilds the burst view of the
   responses: one merged B per write burst and R last on the final beat. */
module axi_burst_splitter import axi_full_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  full_aw_t s_aw_i,
  input  logic     s_aw_valid_i,
  output logic     s_aw_ready_o,
  input  full_w_t  s_w_i,
  input  logic     s_w_valid_i,
  output logic     s_w_ready_o,
  output full_b_t  s_b_o,
  output logic     s_b_valid_o,
  input  logic     s_b_ready_i,
  input  full_ar_t s_ar_i,
  input  logic     s_ar_valid_i,
  output logic     s_ar_ready_o,
  output full_r_t  s_r_o,
  output logic     s_r_valid_o,
  input  logic     s_r_ready_i,
  axi_single_if.mst single
);
  logic     w_active, aw_done, b_pend, aw_ready_q;
  full_aw_t aw_q;
  addr_t    aw_addr_q;
  len_t     aw_cnt_q, b_cnt_q;
  resp_e    b_resp_q;
  id_t      b_id_q;
  logic     r_active, ar_done, ar_ready_q;
  full_ar_t ar_q;
  addr_t    ar_addr_q;
  len_t     ar_cnt_q, r_cnt_q;
  logic     s_aw_hs, sub_aw_hs, sub_b_hs, s_b_hs;
  logic     s_ar_hs, sub_ar_hs, sub_r_hs, r_last;

  // FIXED repeats the address, INCR and WRAP step by 2**size
  function automatic addr_t next_addr(addr_t addr, size_t size, burst_e burst);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + (addr_t'(1) << size);
  endfunction

  // Severity order DECERR, SLVERR, OKAY
  function automatic resp_e worst_resp(resp_e a, resp_e b);
    if (a == RESP_DECERR || b == RESP_DECERR) begin
      return RESP_DECERR;
    end
    if (a == RESP_SLVERR || b == RESP_SLVERR) begin
      return RESP_SLVERR;
    end
    return RESP_OKAY;
  endfunction

  assign s_aw_ready_o   = aw_ready_q;
  assign s_aw_hs        = s_aw_valid_i & s_aw_ready_o;
  assign single.aw      = '{id: aw_q.id, addr: aw_addr_q, len: '0,
                            size: aw_q.size, burst: aw_q.burst};
  assign single.aw_valid = w_active & ~aw_done;
  assign sub_aw_hs      = single.aw_valid & single.aw_ready;

  // Data beats pass straight through as complete transactions
  assign single.w       = '{data: s_w_i.data, strb: s_w_i.strb, last: 1'b1};
  assign single.w_valid = s_w_valid_i;
  assign s_w_ready_o    = single.w_ready;

  assign single.b_ready = w_active & ~b_pend;
  assign sub_b_hs       = single.b_valid & single.b_ready;
  assign s_b_o          = '{id: b_id_q, resp: b_resp_q};
  assign s_b_valid_o    = b_pend;
  assign s_b_hs         = s_b_valid_o & s_b_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_active   <= 1'b0;
      aw_done    <= 1'b0;
      b_pend     <= 1'b0;
      aw_ready_q <= 1'b0;
      aw_cnt_q   <= '0;
      b_cnt_q    <= '0;
      b_resp_q   <= RESP_OKAY;
      b_id_q     <= '0;
    end else begin
      if (s_aw_hs) begin
        w_active <= 1'b1;
        aw_done  <= 1'b0;
        aw_cnt_q <= '0;
        b_cnt_q  <= '0;
        b_resp_q <= RESP_OKAY;
      end
      if (sub_aw_hs) begin
        if (aw_cnt_q == aw_q.len) begin
          aw_done <= 1'b1;
        end else begin
          aw_cnt_q <= aw_cnt_q + 1'b1;
        end
      end
      if (sub_b_hs) begin
        b_resp_q <= worst_resp(b_resp_q, single.b.resp);
        // Reflected ID of the sub-responses
        b_id_q   <= single.b.id;
        if (b_cnt_q == aw_q.len) begin
          b_pend <= 1'b1;
        end else begin
          b_cnt_q <= b_cnt_q + 1'b1;
        end
      end
      if (s_b_hs) begin
        w_active <= 1'b0;
        b_pend   <= 1'b0;
      end
      // Ready rises once the burst has retired
      if (s_aw_hs) begin
        aw_ready_q <= 1'b0;
      end else if (!w_active || s_b_hs) begin
        aw_ready_q <= 1'b1;
      end
    end
  end

  assign s_ar_ready_o    = ar_ready_q;
  assign s_ar_hs         = s_ar_valid_i & s_ar_ready_o;
  assign single.ar       = '{id: ar_q.id, addr: ar_addr_q, len: '0,
                             size: ar_q.size, burst: ar_q.burst};
  assign single.ar_valid = r_active & ~ar_done;
  assign sub_ar_hs       = single.ar_valid & single.ar_ready;

  assign r_last          = (r_cnt_q == ar_q.len);
  assign s_r_o           = '{id: single.r.id, data: single.r.data,
                             resp: single.r.resp, last: r_last};
  assign s_r_valid_o     = single.r_valid;
  assign single.r_ready  = s_r_ready_i;
  assign sub_r_hs        = single.r_valid & s_r_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_active   <= 1'b0;
      ar_done    <= 1'b0;
      ar_ready_q <= 1'b0;
      ar_cnt_q   <= '0;
      r_cnt_q    <= '0;
    end else begin
      if (s_ar_hs) begin
        r_active <= 1'b1;
        ar_done  <= 1'b0;
        ar_cnt_q <= '0;
        r_cnt_q  <= '0;
      end
      if (sub_ar_hs) begin
        if (ar_cnt_q == ar_q.len) begin
          ar_done <= 1'b1;
        end else begin
          ar_cnt_q <= ar_cnt_q + 1'b1;
        end
      end
      if (sub_r_hs) begin
        if (r_last) begin
          r_active <= 1'b0;
        end else begin
          r_cnt_q <= r_cnt_q + 1'b1;
        end
      end
      if (s_ar_hs) begin
        ar_ready_q <= 1'b0;
      end else if (!r_active || (sub_r_hs && r_last)) begin
        ar_ready_q <= 1'b1;
      end
    end
  end

  // Burst headers and running sub-addresses
  always_ff @(posedge clk_i) begin
    if (s_aw_hs) begin
      aw_q      <= s_aw_i;
      aw_addr_q <= s_aw_i.addr;
    end else if (sub_aw_hs) begin
      aw_addr_q <= next_addr(aw_addr_q, aw_q.size, aw_q.burst);
    end
    if (s_ar_hs) begin
      ar_q      <= s_ar_i;
      ar_addr_q <= s_ar_i.addr;
    end else if (sub_ar_hs) begin
      ar_addr_q <= next_addr(ar_addr_q, ar_q.size, ar_q.burst);
    end
  end

endmodule

// File: source/axi_conv_defs.svh
/* Bus widths and ID FIFO depth for the AXI4 to AXI4-Lite converter.
   Included by the packages and by modules that size storage from these values. */
`ifndef AXI_CONV_DEFS_SVH
`define AXI_CONV_DEFS_SVH

// Byte address width
`define AXI_ADDR_W 16

// Data bus width, one strobe bit per byte
`define AXI_DATA_W 32

// Transaction ID width
`define AXI_ID_W 4

// Outstanding single-beat transactions per direction
`define AXI_ID_FIFO_DEPTH 4

`endif

// File: source/axi_full_pkg.sv
/* Channel types of the full AXI4 side, shared by the splitter, the reflector
   and the top level. */
`include "axi_conv_defs.svh"

package axi_full_pkg;

  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_DATA_W-1:0]   data_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_ID_W-1:0]     id_t;
  typedef logic [7:0]               len_t;
  typedef logic [2:0]               size_t;

  // WRAP is decoded but handled as INCR
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } full_aw_t;

  // Read request carries the same fields as a write request
  typedef full_aw_t full_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } full_w_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } full_b_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } full_r_t;

endpackage

// File: source/axi_id_reflect.sv
/* Maps single-beat AXI4 onto AXI4-Lite with no added latency. IDs wait in
   two FIFOs and are put back on the matching B and R responses. */
module axi_id_reflect import axi_full_pkg::*, axi_lite_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  axi_single_if.slv single,
  output lite_ax_t m_aw_o,
  output logic     m_aw_valid_o,
  input  logic     m_aw_ready_i,
  output lite_w_t  m_w_o,
  output logic     m_w_valid_o,
  input  logic     m_w_ready_i,
  input  resp_e    m_b_resp_i,
  input  logic     m_b_valid_i,
  output logic     m_b_ready_o,
  output lite_ax_t m_ar_o,
  output logic     m_ar_valid_o,
  input  logic     m_ar_ready_i,
  input  lite_r_t  m_r_i,
  input  logic     m_r_valid_i,
  output logic     m_r_ready_o
);
  // Unprivileged, secure, data access
  localparam logic [2:0] lite_prot = 3'b000;

  logic aw_full, aw_empty, aw_push, aw_pop;
  logic ar_full, ar_empty, ar_push, ar_pop;
  id_t  aw_id, ar_id;

  // Write requests held back while no ID slot is free
  assign m_aw_o          = '{addr: single.aw.addr, prot: lite_prot};
  assign m_aw_valid_o    = single.aw_valid & ~aw_full;
  assign single.aw_ready = m_aw_ready_i & ~aw_full;
  assign aw_push         = m_aw_valid_o & m_aw_ready_i;

  assign m_w_o           = '{data: single.w.data, strb: single.w.strb};
  assign m_w_valid_o     = single.w_valid;
  assign single.w_ready  = m_w_ready_i;

  assign single.b        = '{id: aw_id, resp: m_b_resp_i};
  assign single.b_valid  = m_b_valid_i & ~aw_empty;
  assign m_b_ready_o     = single.b_ready & ~aw_empty;
  assign aw_pop          = single.b_valid & single.b_ready;

  id_fifo u_aw_id_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (aw_push),
    .data_i  (single.aw.id),
    .pop_i   (aw_pop),
    .data_o  (aw_id),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  // Every Lite R is a last beat
  assign m_ar_o          = '{addr: single.ar.addr, prot: lite_prot};
  assign m_ar_valid_o    = single.ar_valid & ~ar_full;
  assign single.ar_ready = m_ar_ready_i & ~ar_full;
  assign ar_push         = m_ar_valid_o & m_ar_ready_i;

  assign single.r        = '{id: ar_id, data: m_r_i.data, resp: m_r_i.resp, last: 1'b1};
  assign single.r_valid  = m_r_valid_i & ~ar_empty;
  assign m_r_ready_o     = single.r_ready & ~ar_empty;
  assign ar_pop          = single.r_valid & single.r_ready;

  id_fifo u_ar_id_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (ar_push),
    .data_i  (single.ar.id),
    .pop_i   (ar_pop),
    .data_o  (ar_id),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

endmodule

// File: source/axi_lite_pkg.sv
/* Channel types of the AXI4-Lite master side. Widths and the response code
   come from the full AXI4 package. */
package axi_lite_pkg;

  import axi_full_pkg::*;

  // Shared by the Lite AW and AR channels
  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } lite_ax_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } lite_w_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } lite_r_t;

endpackage

// File: source/axi_single_if.sv
/* Single-beat AXI4 link between the burst splitter and the ID reflector.
   The splitter connects through mst, the reflector through slv. */
interface axi_single_if import axi_full_pkg::*; ();

  // Requests from the splitter
  full_aw_t aw;
  logic     aw_valid;
  logic     aw_ready;
  full_w_t  w;
  logic     w_valid;
  logic     w_ready;
  full_ar_t ar;
  logic     ar_valid;
  logic     ar_ready;

  // Responses with reflected IDs
  full_b_t  b;
  logic     b_valid;
  logic     b_ready;
  full_r_t  r;
  logic     r_valid;
  logic     r_ready;

  modport mst (
    output aw, aw_valid, w, w_valid, ar, ar_valid, b_ready, r_ready,
    input  aw_ready, w_ready, ar_ready, b, b_valid, r, r_valid
  );

  modport slv (
    input  aw, aw_valid, w, w_valid, ar, ar_valid, b_ready, r_ready,
    output aw_ready, w_ready, ar_ready, b, b_valid, r, r_valid
  );

endinterface

// File: source/axi_to_axi_lite.sv
/* AXI4 slave to AXI4-Lite master converter. Bursts are split first, then
   the single beats lose their ID while it waits in the reflector. */
module axi_to_axi_lite import axi_full_pkg::*, axi_lite_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Full AXI4 slave port
  input  full_aw_t s_aw_i,
  input  logic     s_aw_valid_i,
  output logic     s_aw_ready_o,
  input  full_w_t  s_w_i,
  input  logic     s_w_valid_i,
  output logic     s_w_ready_o,
  output full_b_t  s_b_o,
  output logic     s_b_valid_o,
  input  logic     s_b_ready_i,
  input  full_ar_t s_ar_i,
  input  logic     s_ar_valid_i,
  output logic     s_ar_ready_o,
  output full_r_t  s_r_o,
  output logic     s_r_valid_o,
  input  logic     s_r_ready_i,
  // AXI4-Lite master port
  output lite_ax_t m_aw_o,
  output logic     m_aw_valid_o,
  input  logic     m_aw_ready_i,
  output lite_w_t  m_w_o,
  output logic     m_w_valid_o,
  input  logic     m_w_ready_i,
  input  resp_e    m_b_resp_i,
  input  logic     m_b_valid_i,
  output logic     m_b_ready_o,
  output lite_ax_t m_ar_o,
  output logic     m_ar_valid_o,
  input  logic     m_ar_ready_i,
  input  lite_r_t  m_r_i,
  input  logic     m_r_valid_i,
  output logic     m_r_ready_o
);

  axi_single_if single_bus ();

  axi_burst_splitter u_splitter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_aw_i       (s_aw_i),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_ready_o (s_aw_ready_o),
    .s_w_i        (s_w_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_ready_o  (s_w_ready_o),
    .s_b_o        (s_b_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .s_ar_i       (s_ar_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_r_o        (s_r_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .single       (single_bus.mst)
  );

  axi_id_reflect u_reflect (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .single       (single_bus.slv),
    .m_aw_o       (m_aw_o),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_w_o        (m_w_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready_i),
    .m_b_resp_i   (m_b_resp_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o),
    .m_ar_o       (m_ar_o),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_r_i        (m_r_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o)
  );

endmodule

// File: source/id_fifo.sv
/* Fall-through FIFO for transaction IDs. The oldest entry shows on data_o
   in the same cycle it is written into an empty FIFO slot. */
`include "axi_conv_defs.svh"

module id_fifo import axi_full_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  id_t  data_i,
  input  logic pop_i,
  output id_t  data_o,
  output logic full_o,
  output logic empty_o
);
  localparam int unsigned depth = `AXI_ID_FIFO_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [ptr_w:0]   cnt_t;

  id_t  mem_q [depth];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic do_push;
  logic do_pop;

  // Circular increment, also for depths that are not a power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == cnt_t'(depth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + cnt_t'(do_push) - cnt_t'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: testbench/axi_to_axi_lite_asserts.sv
/* Handshake checks on the converter ports, attached to the top level with bind. */
module axi_to_axi_lite_asserts import axi_full_pkg::*, axi_lite_pkg::*; (
  input logic     clk_i,
  input logic     rst_n_i,
  input full_b_t  s_b_o,
  input logic     s_b_valid_o,
  input logic     s_b_ready_i,
  input full_r_t  s_r_o,
  input logic     s_r_valid_o,
  input logic     s_r_ready_i,
  input lite_ax_t m_aw_o,
  input logic     m_aw_valid_o,
  input logic     m_aw_ready_i,
  input lite_ax_t m_ar_o,
  input logic     m_ar_valid_o,
  input logic     m_ar_ready_i
);

  // A stalled valid keeps its payload until the transfer
  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_b_valid_o && !s_b_ready_i |=> s_b_valid_o && $stable(s_b_o))
    else $error("B valid dropped or B payload changed before transfer");

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_r_valid_o && !s_r_ready_i |=> s_r_valid_o && $stable(s_r_o))
    else $error("R valid dropped or R payload changed before transfer");

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_aw_valid_o && !m_aw_ready_i |=> m_aw_valid_o && $stable(m_aw_o))
    else $error("Lite AW valid dropped or address changed before transfer");

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable(m_ar_o))
    else $error("Lite AR valid dropped or address changed before transfer");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !(s_b_valid_o || s_r_valid_o || m_aw_valid_o || m_ar_valid_o))
    else $error("DUT valid output high while reset is asserted");

endmodule

bind axi_to_axi_lite axi_to_axi_lite_asserts u_asserts (.*);

// File: testbench/axi_to_axi_lite_tb.sv
/* Testbench for the AXI4 to AXI4-Lite converter. Random bursts enter the full port,
   a Lite memory answers behind the DUT and a reference model checks every response. */
`include "axi_conv_defs.svh"

module axi_to_axi_lite_tb import axi_full_pkg::*, axi_lite_pkg::*; ();
  localparam int unsigned n_single  = 20;
  localparam int unsigned n_incr    = 30;
  localparam int unsigned n_fixed   = 15;
  localparam int unsigned n_txn     = 2 * (n_single + n_incr + n_fixed);
  localparam int unsigned mem_words = 2 ** (`AXI_ADDR_W - 2);
  localparam addr_t       err_base  = 16'hC000;
  // Unprivileged, secure, data access
  localparam logic [2:0]  exp_prot  = 3'b000;

  logic     clk_i        = 1'b0;
  logic     rst_n_i      = 1'b0;
  full_aw_t s_aw_i       = '0;
  logic     s_aw_valid_i = 1'b0;
  logic     s_aw_ready_o;
  full_w_t  s_w_i        = '0;
  logic     s_w_valid_i  = 1'b0;
  logic     s_w_ready_o;
  full_b_t  s_b_o;
  logic     s_b_valid_o;
  logic     s_b_ready_i  = 1'b0;
  full_ar_t s_ar_i       = '0;
  logic     s_ar_valid_i = 1'b0;
  logic     s_ar_ready_o;
  full_r_t  s_r_o;
  logic     s_r_valid_o;
  logic     s_r_ready_i  = 1'b0;
  lite_ax_t m_aw_o;
  logic     m_aw_valid_o;
  logic     m_aw_ready_i = 1'b0;
  lite_w_t  m_w_o;
  logic     m_w_valid_o;
  logic     m_w_ready_i  = 1'b0;
  resp_e    m_b_resp_i   = RESP_OKAY;
  logic     m_b_valid_i  = 1'b0;
  logic     m_b_ready_o;
  lite_ax_t m_ar_o;
  logic     m_ar_valid_o;
  logic     m_ar_ready_i = 1'b0;
  lite_r_t  m_r_i        = '0;
  logic     m_r_valid_i  = 1'b0;
  logic     m_r_ready_o;

  // Lite memory behind the DUT and its reference copy
  data_t       lite_mem [mem_words];
  data_t       ref_mem  [mem_words];
  addr_t       lite_aw_q [$];
  lite_w_t     lite_w_q  [$];
  addr_t       lite_ar_q [$];
  logic [31:0] stim_rng = 32'd39;
  logic [31:0] mem_rng  = 32'd39;

  axi_to_axi_lite uut (.*);

  always #4 clk_i = ~clk_i;

  // Halves swapped so the better upper state bits land low
  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return {state[15:0], state[31:16]};
  endfunction

  function automatic data_t fill_word(int unsigned idx);
    return (data_t'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
  endfunction

  function automatic data_t merge_strb(data_t old_word, data_t new_word, strb_t strb);
    data_t merged;
    merged = old_word;
    for (int unsigned b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // FIXED repeats the start address, INCR steps by the 4-byte beat size
  function automatic addr_t beat_address(burst_e burst, addr_t addr, int unsigned beat);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + addr_t'(4 * beat);
  endfunction

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(string test, string what, logic [31:0] expected,
                             logic [31:0] actual);
    assert (expected === actual)
      else stop_run($sformatf("[FAIL] %s %s: expected %h, actual %h",
                              test, what, expected, actual));
  endtask

  task automatic write_burst(string test, burst_e burst, addr_t addr, int unsigned len);
    logic [31:0] rnd;
    id_t         id;
    addr_t       beat_addr;
    resp_e       exp_resp;
    data_t       data;
    strb_t       strb;
    rnd      = lcg_next(stim_rng);
    id       = rnd[3:0];
    exp_resp = RESP_OKAY;
    s_aw_i       <= '{id: id, addr: addr, len: len_t'(len), size: 3'd2, burst: burst};
    s_aw_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!s_aw_ready_o) @(posedge clk_i);
    s_aw_valid_i <= 1'b0;
    for (int unsigned i = 0; i <= len; i++) begin
      data      = lcg_next(stim_rng);
      rnd       = lcg_next(stim_rng);
      strb      = rnd[3:0];
      beat_addr = beat_address(burst, addr, i);
      if (beat_addr >= err_base) begin
        exp_resp = RESP_SLVERR;
      end else begin
        ref_mem[beat_addr[`AXI_ADDR_W-1:2]] =
          merge_strb(ref_mem[beat_addr[`AXI_ADDR_W-1:2]], data, strb);
      end
      s_w_i       <= '{data: data, strb: strb, last: (i == len)};
      s_w_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!s_w_ready_o) @(posedge clk_i);
    end
    s_w_valid_i <= 1'b0;
    // Ready toggles at random while the merged B is awaited
    do begin
      rnd = lcg_next(stim_rng);
      s_b_ready_i <= |rnd[1:0];
      @(posedge clk_i);
    end while (!(s_b_valid_o && s_b_ready_i));
    s_b_ready_i <= 1'b0;
    check_value(test, "b id", 32'(id), 32'(s_b_o.id));
    check_value(test, "b resp", 32'(exp_resp), 32'(s_b_o.resp));
  endtask

  task automatic read_burst(string test, burst_e burst, addr_t addr, int unsigned len);
    logic [31:0] rnd;
    id_t         id;
    addr_t       beat_addr;
    int unsigned beat;
    rnd  = lcg_next(stim_rng);
    id   = rnd[3:0];
    beat = 0;
    s_ar_i       <= '{id: id, addr: addr, len: len_t'(len), size: 3'd2, burst: burst};
    s_ar_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!s_ar_ready_o) @(posedge clk_i);
    s_ar_valid_i <= 1'b0;
    while (beat <= len) begin
      rnd = lcg_next(stim_rng);
      s_r_ready_i <= |rnd[1:0];
      @(posedge clk_i);
      if (s_r_valid_o && s_r_ready_i) begin
        beat_addr = beat_address(burst, addr, beat);
        check_value(test, "r id", 32'(id), 32'(s_r_o.id));
        check_value(test, "r last", 32'(beat == len), 32'(s_r_o.last));
        if (beat_addr >= err_base) begin
          check_value(test, "r resp", 32'(RESP_SLVERR), 32'(s_r_o.resp));
        end else begin
          check_value(test, "r resp", 32'(RESP_OKAY), 32'(s_r_o.resp));
          check_value(test, "r data", ref_mem[beat_addr[`AXI_ADDR_W-1:2]], s_r_o.data);
        end
        beat++;
      end
    end
    s_r_ready_i <= 1'b0;
  endtask

  // Lite memory with random ready gaps and one response in flight per direction
  always @(posedge clk_i) begin : lite_memory
    addr_t       a;
    lite_w_t     w;
    logic [31:0] rnd;
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < mem_words; i++) begin
        lite_mem[i] = fill_word(i);
      end
      m_aw_ready_i <= 1'b0;
      m_w_ready_i  <= 1'b0;
      m_ar_ready_i <= 1'b0;
      m_b_valid_i  <= 1'b0;
      m_r_valid_i  <= 1'b0;
    end else begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        check_value("lite", "aw prot", 32'(exp_prot), 32'(m_aw_o.prot));
        lite_aw_q.push_back(m_aw_o.addr);
      end
      if (m_w_valid_o && m_w_ready_i) begin
        lite_w_q.push_back(m_w_o);
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        check_value("lite", "ar prot", 32'(exp_prot), 32'(m_ar_o.prot));
        lite_ar_q.push_back(m_ar_o.addr);
      end
      if (m_b_valid_i && m_b_ready_o) begin
        m_b_valid_i <= 1'b0;
      end
      if (m_r_valid_i && m_r_ready_o) begin
        m_r_valid_i <= 1'b0;
      end
      if ((!m_b_valid_i || m_b_ready_o) && lite_aw_q.size() > 0 && lite_w_q.size() > 0) begin
        a = lite_aw_q.pop_front();
        w = lite_w_q.pop_front();
        if (a >= err_base) begin
          m_b_resp_i <= RESP_SLVERR;
        end else begin
          lite_mem[a[`AXI_ADDR_W-1:2]] = merge_strb(lite_mem[a[`AXI_ADDR_W-1:2]], w.data, w.strb);
          m_b_resp_i <= RESP_OKAY;
        end
        m_b_valid_i <= 1'b1;
      end
      if ((!m_r_valid_i || m_r_ready_o) && lite_ar_q.size() > 0) begin
        a = lite_ar_q.pop_front();
        if (a >= err_base) begin
          m_r_i <= '{data: '0, resp: RESP_SLVERR};
        end else begin
          m_r_i <= '{data: lite_mem[a[`AXI_ADDR_W-1:2]], resp: RESP_OKAY};
        end
        m_r_valid_i <= 1'b1;
      end
      rnd = lcg_next(mem_rng);
      m_aw_ready_i <= |rnd[1:0];
      m_w_ready_i  <= |rnd[3:2];
      m_ar_ready_i <= |rnd[5:4];
    end
  end

  initial begin : run_tests
    logic [31:0] rnd;
    addr_t       addr;
    int unsigned len;
    for (int unsigned i = 0; i < mem_words; i++) begin
      ref_mem[i] = fill_word(i);
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    for (int unsigned i = 0; i < n_single; i++) begin
      rnd  = lcg_next(stim_rng);
      addr = {rnd[15:2], 2'b00};
      write_burst("single", BURST_INCR, addr, 0);
      read_burst("single", BURST_INCR, addr, 0);
    end
    for (int unsigned i = 0; i < n_incr; i++) begin
      rnd  = lcg_next(stim_rng);
      addr = {rnd[15:2], 2'b00};
      len  = lcg_next(stim_rng) % 16;
      write_burst("incr", BURST_INCR, addr, len);
      read_burst("incr", BURST_INCR, addr, len);
    end
    for (int unsigned i = 0; i < n_fixed; i++) begin
      rnd  = lcg_next(stim_rng);
      addr = {rnd[15:2], 2'b00};
      len  = lcg_next(stim_rng) % 16;
      write_burst("fixed", BURST_FIXED, addr, len);
      read_burst("fixed", BURST_FIXED, addr, len);
    end
    // Nothing left over and no beat lost on the way to memory
    repeat (4) @(posedge clk_i);
    check_value("drain", "b valid", 32'd0, 32'(s_b_valid_o));
    check_value("drain", "r valid", 32'd0, 32'(s_r_valid_o));
    for (int unsigned i = 0; i < mem_words; i++) begin
      check_value("memory", $sformatf("word %0d", i), ref_mem[i], lite_mem[i]);
    end
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    repeat (n_txn * 200 + 10) @(posedge clk_i);
    stop_run($sformatf("timeout: the tests did not finish within %0d cycles",
                       n_txn * 200 + 10));
  end

endmodule
